// File: fetch_req_stage.sv
module fetch_req_stage #(
	parameter int sets = 64,
	localparam int index_w = $clog2(sets),
	localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w
) (
	input logic clk,
	input logic rst_n,
	input logic [icache_pkg::addr_w-1:0] cpu_req_addr,
	input logic cpu_req_valid,
	input logic flush,
	input logic ctrl_idle,
	output logic req_start,
	output logic flush_start,
	output logic [tag_w-1:0] req_tag,
	output logic [index_w-1:0] req_index,
	output logic [icache_pkg::word_sel_w-1:0] req_word
);
	import icache_pkg::*;

	logic can_take; // controller free and nothing already in flight
	logic take_req;
	logic take_flush;

	assign can_take = ctrl_idle && !req_start;
	assign take_flush = can_take && flush;
	assign take_req = can_take && cpu_req_valid && !flush; // flush wins and the request waits

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_start <= 1'b0;
			flush_start <= 1'b0;
		end else begin
			req_start <= take_req;
			flush_start <= take_flush;
		end
	end

	// fields held until the next accepted fetch
	always_ff @(posedge clk) begin
		if (take_req) begin
			{req_tag, req_index, req_word} <= cpu_req_addr[addr_w-1:byte_sel_w];
		end
	end

endmodule

// File: icache_checker.sv
module icache_checker (
	input logic clk,
	input logic rst_n,
	input logic cpu_req_valid,
	input logic flush,
	input logic cpu_ready,
	input logic [icache_pkg::word_w-1:0] cpu_data_read,
	input logic mem_req_valid,
	input logic [icache_pkg::addr_w-1:0] mem_req_addr,
	input int op_num,
	input logic [7:0] op_kind,
	input logic [icache_pkg::addr_w-1:0] op_addr,
	input logic [icache_pkg::word_w-1:0] exp_word,
	input logic exp_miss,
	output int pass_count,
	output int fail_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	localparam int hit_latency = 2; // latch cycle plus lookup cycle

	logic in_flight; // read seen and cpu_ready not yet
	logic saw_mem;
	int cycles;
	int errs;

	initial begin
		in_flight = 1'b0;
		saw_mem = 1'b0;
		cycles = 0;
		errs = 0;
		pass_count = 0;
		fail_count = 0;
	end

	// sampled mid-cycle since inputs move just after the rising edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (in_flight) begin
				cycles++;
			end else if (cpu_req_valid && !flush) begin
				in_flight = 1'b1;
				saw_mem = 1'b0;
				cycles = 0;
				errs = 0;
			end
			if (in_flight && !cpu_ready && cpu_data_read !== '0) begin
				$display("FAILED op %0d cpu_data_read got %h expected %h", op_num,
					cpu_data_read, {word_w{1'b0}});
				errs++;
			end
			if (mem_req_valid) begin
				if (!in_flight) begin
					$display("op %0d: memory request issued with no read waiting", op_num);
					fail_count++;
				end else if (saw_mem) begin
					$display("op %0d: a second memory request for the same read", op_num);
					errs++;
				end else begin
					saw_mem = 1'b1;
					if (mem_req_addr !== {op_addr[addr_w-1:offset_w], {offset_w{1'b0}}}) begin
						$display("FAILED op %0d mem_req_addr got %h expected %h", op_num,
							mem_req_addr, {op_addr[addr_w-1:offset_w], {offset_w{1'b0}}});
						errs++;
					end
				end
			end
			if (cpu_ready) begin
				if (!in_flight) begin
					$display("op %0d: cpu_ready raised with no read waiting", op_num);
					fail_count++;
				end else begin
					if (cpu_data_read !== exp_word) begin
						$display("FAILED op %0d cpu_data_read got %h expected %h", op_num,
							cpu_data_read, exp_word);
						errs++;
					end
					if (saw_mem !== exp_miss) begin
						$display("FAILED op %0d mem_req_valid got %h expected %h", op_num,
							saw_mem, exp_miss);
						errs++;
					end
					if (!exp_miss && cycles != hit_latency) begin
						$display("FAILED op %0d cpu_ready latency got %h expected %h", op_num,
							cycles, hit_latency);
						errs++;
					end
					if (errs == 0) begin
						$display("op %0d %c %h passed", op_num, op_kind, op_addr);
						pass_count++;
					end else begin
						$display("op %0d %c %h failed", op_num, op_kind, op_addr);
						fail_count++;
					end
					in_flight = 1'b0;
				end
			end
			if (flush && op_kind == "F") begin
				$display("op %0d F flush passed", op_num); // one sample per pulse
				pass_count++;
			end
		end
	end

endmodule

// File: icache_ctrl.sv
module icache_ctrl (
	input logic clk,
	input logic rst_n,
	input logic req_start,
	input logic flush_start,
	input logic hit,
	input logic refill_done,
	output logic ctrl_idle,
	output logic lookup_en,
	output logic flush_en,
	output logic refill_start,
	output logic cpu_ready
);
	import icache_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= idle;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			idle: begin
				if (req_start) begin
					state_d = lookup;
				end
			end
			lookup: begin
				if (hit) begin
					state_d = idle;
				end else begin
					state_d = refill;
				end
			end
			refill: begin
				if (refill_done) begin
					state_d = relookup;
				end
			end
			relookup: begin
				state_d = idle; // line was just written, so this always hits
			end
			default: begin
				state_d = idle;
			end
		endcase
	end

	assign ctrl_idle = (state_q == idle);
	assign lookup_en = (state_q == lookup) || (state_q == relookup);
	assign flush_en = flush_start && (state_q == idle);
	assign refill_start = (state_q == lookup) && !hit; // one cycle on leaving lookup
	assign cpu_ready = lookup_en && hit;

	// the fetch stage only starts work while the FSM is idle
	assert property (@(posedge clk) disable iff (!rst_n)
		(req_start || flush_start) |-> (state_q == idle) && !(req_start && flush_start))
		else $error("start pulse outside idle in state %s", state_q.name());

	// the line written during refill must be found by the relookup
	assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == relookup) |-> hit)
		else $error("relookup missed after refill");

endmodule

// File: icache_pkg.sv
package icache_pkg;

	// fetch address and bus widths
	localparam int addr_w = 32;
	localparam int word_w = 64;

	// four 64-bit words per 32-byte line
	localparam int words_per_line = 4;
	localparam int word_sel_w = $clog2(words_per_line); // address bits 4:3
	localparam int byte_sel_w = 3; // byte within a word is ignored on fetch
	localparam int offset_w = word_sel_w + byte_sel_w;

	// word 0 sits in the low 64 bits
	typedef logic [words_per_line-1:0][word_w-1:0] line_t;

	// controller sequencing
	typedef enum logic [1:0] {
		idle, // waiting for a fetch or flush
		lookup, // first tag compare
		refill, // miss while the line comes from memory
		relookup // compare again on the freshly written line
	} ctrl_state_e;

endpackage

// File: icache_top.sv
module icache_top #(
	parameter int sets = 64,
	localparam int index_w = $clog2(sets),
	localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w
) (
	input logic clk,
	input logic rst_n,
	input logic [icache_pkg::addr_w-1:0] cpu_req_addr,
	input logic cpu_req_valid,
	input logic flush,
	output logic [icache_pkg::word_w-1:0] cpu_data_read,
	output logic cpu_ready,
	output logic [icache_pkg::addr_w-1:0] mem_req_addr,
	output logic mem_req_valid,
	input logic [icache_pkg::word_w-1:0] mem_data_read,
	input logic mem_ready
);
	import icache_pkg::*;

	logic ctrl_idle;
	logic req_start;
	logic flush_start;
	logic [tag_w-1:0] req_tag;
	logic [index_w-1:0] req_index;
	logic [word_sel_w-1:0] req_word;
	logic lookup_en;
	logic flush_en;
	logic refill_start;
	logic refill_done;
	logic hit;
	logic victim_way;

	line_write_if #(.sets(sets)) lw_bus ();

	fetch_req_stage #(.sets(sets)) fetch_req_stage_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req_addr(cpu_req_addr),
		.cpu_req_valid(cpu_req_valid),
		.flush(flush),
		.ctrl_idle(ctrl_idle),
		.req_start(req_start),
		.flush_start(flush_start),
		.req_tag(req_tag),
		.req_index(req_index),
		.req_word(req_word)
	);

	icache_ctrl icache_ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.req_start(req_start),
		.flush_start(flush_start),
		.hit(hit),
		.refill_done(refill_done),
		.ctrl_idle(ctrl_idle),
		.lookup_en(lookup_en),
		.flush_en(flush_en),
		.refill_start(refill_start),
		.cpu_ready(cpu_ready)
	);

	icache_ways #(.sets(sets)) icache_ways_inst (
		.clk(clk),
		.rst_n(rst_n),
		.lookup_en(lookup_en),
		.flush_en(flush_en),
		.req_tag(req_tag),
		.req_index(req_index),
		.req_word(req_word),
		.lw(lw_bus.sink),
		.hit(hit),
		.victim_way(victim_way),
		.rd_word(cpu_data_read)
	);

	refill_unit #(.sets(sets)) refill_unit_inst (
		.clk(clk),
		.rst_n(rst_n),
		.refill_start(refill_start),
		.req_tag(req_tag),
		.req_index(req_index),
		.victim_way(victim_way),
		.mem_data_read(mem_data_read),
		.mem_ready(mem_ready),
		.mem_req_addr(mem_req_addr),
		.mem_req_valid(mem_req_valid),
		.refill_done(refill_done),
		.lw(lw_bus.source)
	);

endmodule

// File: icache_trace.txt
# op (R read, F flush, B flush raised together with a read) address expected_word miss
# expected word of beat k for line L is {L, ~L + k}, k from address bits 4:3
R 00000020 00000020ffffffdf 1
R 00000038 00000020ffffffe2 0
R 00000828 00000820fffff7e0 1
R 00000030 00000020ffffffe1 0
R 00000830 00000820fffff7e1 0
R 00001020 00001020ffffefdf 1
R 00000838 00000820fffff7e2 0
R 00000028 00000020ffffffe0 1
R 00000820 00000820fffff7df 0
R 00012358 00012340fffedcc2 1
R 00012340 00012340fffedcbf 0
F 00000000 0000000000000000 0
R 00000020 00000020ffffffdf 1
R 00012348 00012340fffedcc0 1
R 00000020 00000020ffffffdf 0
B 00000038 00000020ffffffe2 1
R 00000030 00000020ffffffe1 0
R 00012340 00012340fffedcbf 1
R deadbee8 deadbee021524120 1
R deadbef8 deadbee021524122 0
R 80000000 800000007fffffff 1
R 80000018 8000000080000002 0
R ffffffe0 ffffffe00000001f 1
R fffffff0 ffffffe000000021 0
R 00000820 00000820fffff7df 1
R 00000020 00000020ffffffdf 0

// File: icache_ways.sv
module icache_ways #(
	parameter int sets = 64,
	localparam int index_w = $clog2(sets),
	localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w
) (
	input logic clk,
	input logic rst_n,
	input logic lookup_en,
	input logic flush_en,
	input logic [tag_w-1:0] req_tag,
	input logic [index_w-1:0] req_index,
	input logic [icache_pkg::word_sel_w-1:0] req_word,
	line_write_if.sink lw,
	output logic hit,
	output logic victim_way,
	output logic [icache_pkg::word_w-1:0] rd_word
);
	import icache_pkg::*;

	logic [tag_w-1:0] tag_mem [2][sets];
	line_t data_mem [2][sets];
	logic [1:0][sets-1:0] valid_q;
	logic [sets-1:0] lru_q; // bit names the way to evict next
	logic [1:0] way_hit;
	logic hit_way;

	// tag and data arrays are written once per refill
	always_ff @(posedge clk) begin
		if (lw.wr_en) begin
			tag_mem[lw.wr_way][lw.wr_index] <= lw.wr_tag;
			data_mem[lw.wr_way][lw.wr_index] <= lw.wr_line;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (flush_en) begin
			valid_q <= '0; // whole cache at once
		end else if (lw.wr_en) begin
			valid_q[lw.wr_way][lw.wr_index] <= 1'b1;
		end
	end

	// point lru at the way that was not just touched
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lru_q <= '0;
		end else if (lw.wr_en) begin
			lru_q[lw.wr_index] <= ~lw.wr_way;
		end else if (hit) begin
			lru_q[req_index] <= ~hit_way;
		end
	end

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = lookup_en && valid_q[w][req_index]
				&& (tag_mem[w][req_index] == req_tag);
		end
	end

	assign hit = |way_hit;
	assign hit_way = way_hit[1];

	always_comb begin
		rd_word = '0; // nothing on the bus without a hit
		if (hit) begin
			rd_word = data_mem[hit_way][req_index][req_word];
		end
	end

	// empty way first and the lower one wins
	always_comb begin
		if (!valid_q[0][req_index]) begin
			victim_way = 1'b0;
		end else if (!valid_q[1][req_index]) begin
			victim_way = 1'b1;
		end else begin
			victim_way = lru_q[req_index];
		end
	end

	// a refill must never place a second copy of a line in the set
	assert property (@(posedge clk) disable iff (!rst_n)
		!(way_hit[0] && way_hit[1]))
		else $error("both ways hit for set %0d", req_index);

	// line writes only land while the controller is waiting on refill
	assert property (@(posedge clk) disable iff (!rst_n)
		!(lw.wr_en && lookup_en))
		else $error("line write during lookup");

endmodule

// File: line_write_if.sv
interface line_write_if #(
	parameter int sets = 64,
	localparam int index_w = $clog2(sets),
	localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w
);
	import icache_pkg::*;

	logic wr_en; // single-cycle write strobe
	logic wr_way;
	logic [index_w-1:0] wr_index;
	logic [tag_w-1:0] wr_tag;
	line_t wr_line;

	// refill side
	modport source (
		output wr_en,
		output wr_way,
		output wr_index,
		output wr_tag,
		output wr_line
	);

	// way storage side
	modport sink (
		input wr_en,
		input wr_way,
		input wr_index,
		input wr_tag,
		input wr_line
	);

endinterface

// File: refill_unit.sv
module refill_unit #(
	parameter int sets = 64,
	localparam int index_w = $clog2(sets),
	localparam int tag_w = icache_pkg::addr_w - index_w - icache_pkg::offset_w
) (
	input logic clk,
	input logic rst_n,
	input logic refill_start,
	input logic [tag_w-1:0] req_tag,
	input logic [index_w-1:0] req_index,
	input logic victim_way,
	input logic [icache_pkg::word_w-1:0] mem_data_read,
	input logic mem_ready,
	output logic [icache_pkg::addr_w-1:0] mem_req_addr,
	output logic mem_req_valid,
	output logic refill_done,
	line_write_if.source lw
);
	import icache_pkg::*;

	logic open_q; // a refill is waiting for beats
	logic [word_sel_w-1:0] beat_q;
	logic done_q;
	logic way_q;
	logic beat_in;
	logic last_beat;
	line_t line_q;

	// request goes out in the same cycle the miss is seen
	assign mem_req_valid = refill_start;
	assign mem_req_addr = {req_tag, req_index, {offset_w{1'b0}}}; // line aligned

	assign beat_in = open_q && mem_ready;
	assign last_beat = beat_in && (beat_q == word_sel_w'(words_per_line - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			open_q <= 1'b0;
			beat_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= last_beat;
			if (refill_start) begin
				open_q <= 1'b1;
				beat_q <= '0;
			end else if (beat_in) begin
				beat_q <= beat_q + 1'b1;
				if (last_beat) begin
					open_q <= 1'b0;
				end
			end
		end
	end

	// beats arrive in word order
	always_ff @(posedge clk) begin
		if (refill_start) begin
			way_q <= victim_way;
		end
		if (beat_in) begin
			line_q[beat_q] <= mem_data_read;
		end
	end

	assign refill_done = done_q;

	// fields stay held by the fetch stage for the whole refill
	assign lw.wr_en = done_q;
	assign lw.wr_way = way_q;
	assign lw.wr_index = req_index;
	assign lw.wr_tag = req_tag;
	assign lw.wr_line = line_q;

	assert property (@(posedge clk) disable iff (!rst_n)
		mem_ready |-> open_q)
		else $error("mem_ready beat with no refill open");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_icache -f vlog.f -o sim_icache \
	&& ./obj_dir/sim_icache | tee sim.log \
	|| { echo "build or simulation did not complete"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: tb_icache.sv
module tb_icache;
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	localparam int clk_period = 8;
	localparam int reset_cycles = 4;
	localparam int cycles_per_op = 40; // a miss with 3-cycle beat gaps stays far below
	localparam int max_ops = 64;
	localparam logic [31:0] rand_seed = 32'h748;

	logic clk;
	logic rst_n;
	logic [addr_w-1:0] cpu_req_addr;
	logic cpu_req_valid;
	logic flush;
	logic [word_w-1:0] cpu_data_read;
	logic cpu_ready;
	logic [addr_w-1:0] mem_req_addr;
	logic mem_req_valid;
	logic [word_w-1:0] mem_data_read;
	logic mem_ready;

	logic [7:0] trace_kind [max_ops];
	logic [addr_w-1:0] trace_addr [max_ops];
	logic [word_w-1:0] trace_word [max_ops];
	logic trace_miss [max_ops];
	int n_ops;
	logic trace_loaded;
	bit load_ok;

	// operation in progress as the checker sees it
	int op_num;
	logic [7:0] op_kind;
	logic [addr_w-1:0] op_addr;
	logic [word_w-1:0] exp_word;
	logic exp_miss;
	int pass_count;
	int fail_count;

	logic [addr_w-1:0] line_addr;
	int gap;

	icache_top #(.sets(64)) icache_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req_addr(cpu_req_addr),
		.cpu_req_valid(cpu_req_valid),
		.flush(flush),
		.cpu_data_read(cpu_data_read),
		.cpu_ready(cpu_ready),
		.mem_req_addr(mem_req_addr),
		.mem_req_valid(mem_req_valid),
		.mem_data_read(mem_data_read),
		.mem_ready(mem_ready)
	);

	icache_checker icache_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_req_valid(cpu_req_valid),
		.flush(flush),
		.cpu_ready(cpu_ready),
		.cpu_data_read(cpu_data_read),
		.mem_req_valid(mem_req_valid),
		.mem_req_addr(mem_req_addr),
		.op_num(op_num),
		.op_kind(op_kind),
		.op_addr(op_addr),
		.exp_word(exp_word),
		.exp_miss(exp_miss),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	// upper half is the line address and the lower half its inverse plus the beat number
	function automatic logic [word_w-1:0] memory_beat(input logic [addr_w-1:0] base, input int k);
		logic [addr_w-1:0] low_half;
		low_half = ~base + addr_w'(k);
		return {base, low_half};
	endfunction

	task automatic load_trace(output bit ok);
		int fd;
		int n;
		string line;
		logic [7:0] kind;
		logic [addr_w-1:0] addr;
		logic [word_w-1:0] word;
		logic [3:0] miss;
		ok = 1'b0;
		n_ops = 0;
		fd = $fopen("icache_trace.txt", "r");
		if (fd == 0) begin
			return;
		end
		while (!$feof(fd) && n_ops < max_ops) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%c %h %h %h", kind, addr, word, miss);
			if (n == 4 && (kind == "R" || kind == "F" || kind == "B")) begin // '#' lines drop out
				trace_kind[n_ops] = kind;
				trace_addr[n_ops] = addr;
				trace_word[n_ops] = word;
				trace_miss[n_ops] = miss[0];
				n_ops++;
			end
		end
		$fclose(fd);
		ok = (n_ops > 0);
	endtask

	task automatic wait_ready();
		do begin
			@(negedge clk);
		end while (!cpu_ready);
		@(posedge clk);
		#1;
	endtask

	// entered and left 1 ns after a rising edge
	task automatic run_op(input int i);
		op_num = i;
		op_kind = trace_kind[i];
		op_addr = trace_addr[i];
		exp_word = trace_word[i];
		exp_miss = trace_miss[i];
		cpu_req_addr = trace_addr[i];
		if (trace_kind[i] == "F") begin
			flush = 1'b1;
			@(posedge clk);
			#1 flush = 1'b0;
		end else begin
			cpu_req_valid = 1'b1;
			if (trace_kind[i] == "B") begin
				flush = 1'b1; // read has to wait behind it
				@(posedge clk);
				#1 flush = 1'b0;
			end
			wait_ready();
			cpu_req_valid = 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		cpu_req_addr = '0;
		cpu_req_valid = 1'b0;
		flush = 1'b0;
		op_num = 0;
		op_kind = "-";
		op_addr = '0;
		exp_word = '0;
		exp_miss = 1'b0;
		trace_loaded = 1'b0;
		load_trace(load_ok);
		trace_loaded = load_ok;
		if (!load_ok) begin
			$display("could not read any operation from icache_trace.txt");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			repeat (reset_cycles) @(posedge clk);
			#1 rst_n = 1'b1;
			for (int i = 0; i < n_ops; i++) begin
				run_op(i);
			end
			repeat (4) @(posedge clk);
			$display("tests run %0d, passed %0d, failed %0d", n_ops, pass_count, fail_count);
			if (fail_count == 0 && pass_count == n_ops) begin
				$display("TESTBENCH PASSED");
			end else begin
				$display("TESTBENCH FAILED");
			end
			$finish;
		end
	end

	// memory model answering each request with four beats and random gaps
	initial begin
		mem_ready = 1'b0;
		mem_data_read = '0;
		void'($urandom(rand_seed));
		forever begin
			@(negedge clk);
			if (rst_n && mem_req_valid) begin
				line_addr = mem_req_addr;
				@(posedge clk);
				#1;
				for (int k = 0; k < words_per_line; k++) begin
					gap = $urandom % 4;
					if (gap != 0) begin
						mem_ready = 1'b0;
						repeat (gap) @(posedge clk);
						#1;
					end
					mem_ready = 1'b1;
					mem_data_read = memory_beat(line_addr, k);
					@(posedge clk);
					#1;
				end
				mem_ready = 1'b0;
				mem_data_read = '0;
			end
		end
	end

	initial begin
		wait (trace_loaded);
		repeat (n_ops * cycles_per_op + reset_cycles) @(posedge clk);
		$display("simulation timed out after %0d cycles before the trace finished",
			n_ops * cycles_per_op + reset_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: vlog.f
icache_pkg.sv
line_write_if.sv
fetch_req_stage.sv
icache_ctrl.sv
icache_ways.sv
refill_unit.sv
icache_top.sv
icache_checker.sv
tb_icache.sv
